// File: fetch_top.f
source/fetch_pkg.sv
source/lookup_table.sv
source/direction_predictor.sv
source/target_buffer.sv
source/next_ip_gen.sv
source/fetch_top.sv
tests/fetch_top_assertions.sv
tests/fetch_top_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fetch_top_tb \
  -f fetch_top.f -o fetch_sim

out=$(./obj_dir/fetch_sim 2>&1) || { echo "$out"; exit 1; }
echo "$out"

if echo "$out" | grep -q "^Simulation finished: PASS$"; then
  exit 0
else
  exit 1
fi

// File: source/direction_predictor.sv
`timescale 1ns/1ns

module direction_predictor import fetch_pkg::*; #(
  parameter int HIST_A = 2,
  parameter int HIST_B = 4,
  parameter int HIST_C = 7
) (
  input  logic        clk,
  input  logic        rst,
  input  addr_t       ip,
  input  ghist_t      ghist,
  input  retire_upd_t retire,
  output logic [1:0]  pred_dir
);

  logic      train;
  logic [3:0] miss_cnt;
  logic [2:0] tbl_we;
  pred_ctr_t flip_mask;
  pred_ctr_t tbl_data [3];

  assign train = retire.valid & retire.mispredict;
  assign flip_mask = retire.slot ? 2'b10 : 2'b01;

  // A every mispredict, B every 4th, C every 16th
  assign tbl_we[0] = train;
  assign tbl_we[1] = train & (miss_cnt[1:0] == 2'b11);
  assign tbl_we[2] = train & (miss_cnt == 4'hf);

  always_ff @(posedge clk) begin
    if (rst) begin
      miss_cnt <= '0;
    end else if (train) begin
      miss_cnt <= miss_cnt + 4'd1;
    end
  end

  for (genvar t = 0; t < 3; t++) begin : g_table
    localparam int H = (t == 0) ? HIST_A : (t == 1) ? HIST_B : HIST_C;

    logic [PRED_IDX_BITS-1:0] fetch_idx;
    logic [PRED_IDX_BITS-1:0] ret_idx;
    logic [PRED_IDX_BITS-1:0] rd_idx;

    assign fetch_idx = {ip[BLOCK_LSB +: PRED_IDX_BITS-H], ghist[H-1:0]};
    assign ret_idx = {retire.src_ip[BLOCK_LSB +: PRED_IDX_BITS-H], retire.ghist[H-1:0]};

    // training borrows the read port; the redirect drops this cycle's prediction
    assign rd_idx = train ? ret_idx : fetch_idx;

    lookup_table #(
      .entry_t (pred_ctr_t),
      .IDX_BITS(PRED_IDX_BITS)
    ) table_i (
      .clk    (clk),
      .rst    (rst),
      .rd_idx (rd_idx),
      .rd_data(tbl_data[t]),
      .wr_en  (tbl_we[t]),
      .wr_idx (ret_idx),
      .wr_data(tbl_data[t] ^ flip_mask)
    );
  end

  assign pred_dir = tbl_data[0] ^ tbl_data[1] ^ tbl_data[2];

endmodule

// File: source/fetch_pkg.sv
package fetch_pkg;

  localparam int ADDR_BITS = 32;
  typedef logic [ADDR_BITS-1:0] addr_t;

  // fetch block geometry
  localparam int FETCH_BYTES = 16;
  localparam int BLOCK_LSB = 4;

  localparam int GHIST_BITS = 8;
  typedef logic [GHIST_BITS-1:0] ghist_t;

  // every direction table is indexed by 8 bits
  localparam int PRED_IDX_BITS = 8;

  // bit 0 is slot 0 taken, bit 1 is slot 1 taken
  typedef logic [1:0] pred_ctr_t;

  // address bits above the block offset and a 6-bit buffer index
  localparam int TB_TAG_BITS = ADDR_BITS - BLOCK_LSB - 6;

  typedef struct packed {
    logic                   valid;
    logic [TB_TAG_BITS-1:0] tag;
    addr_t                  target;
  } target_entry_t;

  typedef struct packed {
    addr_t      ip;
    ghist_t     ghist;     // history used for the prediction
    logic [1:0] pred_slot; // one-hot taken slot, 0 = fall-through
  } fetch_req_t;

  typedef struct packed {
    logic   valid;
    logic   slot;
    logic   taken;
    logic   mispredict;
    addr_t  src_ip;   // block holding the branch
    addr_t  target;   // resolved target
    ghist_t ghist;    // history at prediction
  } retire_upd_t;

endpackage

// File: source/fetch_top.sv
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; #(
  parameter addr_t INIT_IP     = 32'h0000_1000,
  parameter int    TB_IDX_BITS = 6,
  parameter int    HIST_A      = 2,
  parameter int    HIST_B      = 4,
  parameter int    HIST_C      = 7
) (
  input  logic        clk,
  input  logic        rst,
  output fetch_req_t  fetch,
  output logic        fetch_valid,
  input  logic        fetch_ready,
  input  retire_upd_t retire,
  output logic        alias_error
);

  addr_t       ip;
  ghist_t      ghist;
  logic [1:0]  pred_dir;
  logic [1:0]  slot_hit;
  addr_t [1:0] slot_target;

  direction_predictor #(
    .HIST_A(HIST_A),
    .HIST_B(HIST_B),
    .HIST_C(HIST_C)
  ) dir_pred_i (
    .clk     (clk),
    .rst     (rst),
    .ip      (ip),
    .ghist   (ghist),
    .retire  (retire),
    .pred_dir(pred_dir)
  );

  target_buffer #(
    .TB_IDX_BITS(TB_IDX_BITS)
  ) tbuf_i (
    .clk        (clk),
    .rst        (rst),
    .ip         (ip),
    .retire     (retire),
    .slot_hit   (slot_hit),
    .slot_target(slot_target)
  );

  next_ip_gen #(
    .INIT_IP(INIT_IP)
  ) next_ip_i (
    .clk        (clk),
    .rst        (rst),
    .pred_dir   (pred_dir),
    .slot_hit   (slot_hit),
    .slot_target(slot_target),
    .retire     (retire),
    .fetch      (fetch),
    .fetch_valid(fetch_valid),
    .fetch_ready(fetch_ready),
    .ip         (ip),
    .ghist      (ghist),
    .alias_error(alias_error)
  );

endmodule

// File: source/lookup_table.sv
`timescale 1ns/1ns

module lookup_table #(
  parameter type entry_t = logic,
  parameter int  IDX_BITS = 8
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [IDX_BITS-1:0] rd_idx,
  output entry_t              rd_data,
  input  logic                wr_en,
  input  logic [IDX_BITS-1:0] wr_idx,
  input  entry_t              wr_data
);

  localparam int DEPTH = 1 << IDX_BITS;

  entry_t mem [DEPTH];

  assign rd_data = mem[rd_idx]; // async read, write shows next cycle

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

endmodule

// File: source/next_ip_gen.sv
`timescale 1ns/1ns

module next_ip_gen import fetch_pkg::*; #(
  parameter addr_t INIT_IP = 32'h0000_1000
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [1:0]  pred_dir,
  input  logic [1:0]  slot_hit,
  input  addr_t [1:0] slot_target,
  input  retire_upd_t retire,
  output fetch_req_t  fetch,
  output logic        fetch_valid,
  input  logic        fetch_ready,
  output addr_t       ip,
  output ghist_t      ghist,
  output logic        alias_error
);

  // slot 0 taken adds 1, slot 1 taken adds 0 then 1, fall-through adds 00
  function automatic ghist_t next_hist(input ghist_t h, input logic taken, input logic slot);
    ghist_t res;
    if (taken && !slot) begin
      res = {h[GHIST_BITS-2:0], 1'b1};
    end else if (taken) begin
      res = {h[GHIST_BITS-3:0], 2'b01};
    end else begin
      res = {h[GHIST_BITS-3:0], 2'b00};
    end
    return res;
  endfunction

  addr_t      ip_q;
  addr_t      ip_next;
  ghist_t     ghist_q;
  ghist_t     ghist_next;
  logic       valid_q;
  logic       alias_q;
  logic       accept;
  logic       redirect;
  logic       alias_hit;
  logic [1:0] take;

  assign accept = valid_q & fetch_ready;
  assign redirect = retire.valid & retire.mispredict; // beats an accepted block

  assign take[0] = pred_dir[0] & slot_hit[0];
  assign take[1] = ~take[0] & pred_dir[1] & slot_hit[1];

  assign alias_hit = accept & ~redirect &
                     ((pred_dir[0] & ~slot_hit[0]) | (~take[0] & pred_dir[1] & ~slot_hit[1]));

  always_comb begin
    ip_next = ip_q;
    ghist_next = ghist_q;
    if (redirect) begin
      ghist_next = next_hist(retire.ghist, retire.taken, retire.slot);
      if (retire.taken) begin
        ip_next = {retire.target[ADDR_BITS-1:BLOCK_LSB], {BLOCK_LSB{1'b0}}};
      end else begin
        ip_next = {retire.src_ip[ADDR_BITS-1:BLOCK_LSB], {BLOCK_LSB{1'b0}}}
                  + addr_t'(FETCH_BYTES);
      end
    end else if (accept) begin
      ghist_next = next_hist(ghist_q, |take, take[1]);
      if (take[0]) begin
        ip_next = slot_target[0];
      end else if (take[1]) begin
        ip_next = slot_target[1];
      end else begin
        ip_next = ip_q + addr_t'(FETCH_BYTES);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ip_q    <= INIT_IP;
      ghist_q <= '0;
      valid_q <= 1'b0;
      alias_q <= 1'b0;
    end else begin
      ip_q    <= ip_next;
      ghist_q <= ghist_next;
      valid_q <= 1'b1;
      if (alias_hit) alias_q <= 1'b1; // sticky
    end
  end

  assign fetch = '{ip: ip_q, ghist: ghist_q, pred_slot: take};
  assign fetch_valid = valid_q;
  assign ip = ip_q;
  assign ghist = ghist_q;
  assign alias_error = alias_q;

endmodule

// File: source/target_buffer.sv
`timescale 1ns/1ns

module target_buffer import fetch_pkg::*; #(
  parameter int TB_IDX_BITS = 6
) (
  input  logic            clk,
  input  logic            rst,
  input  addr_t           ip,
  input  retire_upd_t     retire,
  output logic [1:0]      slot_hit,
  output addr_t [1:0]     slot_target
);

  logic [TB_IDX_BITS-1:0] fetch_idx;
  logic [TB_IDX_BITS-1:0] ret_idx;
  logic [TB_TAG_BITS-1:0] fetch_tag;
  logic [TB_TAG_BITS-1:0] ret_tag;
  target_entry_t          wr_entry;

  assign fetch_idx = ip[BLOCK_LSB +: TB_IDX_BITS];
  assign ret_idx = retire.src_ip[BLOCK_LSB +: TB_IDX_BITS];

  // everything above the index is tag
  assign fetch_tag = TB_TAG_BITS'(ip >> (BLOCK_LSB + TB_IDX_BITS));
  assign ret_tag = TB_TAG_BITS'(retire.src_ip >> (BLOCK_LSB + TB_IDX_BITS));

  // targets kept block aligned
  assign wr_entry = '{
    valid:  1'b1,
    tag:    ret_tag,
    target: {retire.target[ADDR_BITS-1:BLOCK_LSB], {BLOCK_LSB{1'b0}}}
  };

  for (genvar s = 0; s < 2; s++) begin : g_slot
    target_entry_t rd_entry;
    logic          wr_en;

    assign wr_en = retire.valid & retire.taken & (retire.slot == 1'(s));

    lookup_table #(
      .entry_t (target_entry_t),
      .IDX_BITS(TB_IDX_BITS)
    ) table_i (
      .clk    (clk),
      .rst    (rst),
      .rd_idx (fetch_idx),
      .rd_data(rd_entry),
      .wr_en  (wr_en),
      .wr_idx (ret_idx),
      .wr_data(wr_entry)
    );

    // a miss on a predicted slot is an alias, flagged by the pointer logic
    assign slot_hit[s] = rd_entry.valid && (rd_entry.tag == fetch_tag);
    assign slot_target[s] = rd_entry.target;
  end

endmodule

// File: tests/fetch_top_assertions.sv
`timescale 1ns/1ns

module fetch_top_assertions import fetch_pkg::*; (
  input logic        clk,
  input logic        rst,
  input fetch_req_t  fetch,
  input logic        fetch_valid,
  input logic        fetch_ready,
  input retire_upd_t retire
);

  int unsigned err_count = 0; // read back by the testbench

  // the cycle after any reset cycle still has no block
  valid_low_in_reset: assert property (@(posedge clk) rst |=> !fetch_valid)
    else begin
      $error("fetch_valid high after a reset cycle");
      err_count++;
    end

  // stalled block holds unless a mispredict redirects
  ip_held_on_stall: assert property (@(posedge clk) disable iff (rst)
    fetch_valid && !fetch_ready && !(retire.valid && retire.mispredict)
    |=> $stable(fetch.ip))
    else begin
      $error("fetch.ip changed while stalled");
      err_count++;
    end

  ip_block_aligned: assert property (@(posedge clk) disable iff (rst)
    fetch_valid |-> (fetch.ip[BLOCK_LSB-1:0] == '0))
    else begin
      $error("fetch.ip not 16-byte aligned");
      err_count++;
    end

endmodule

bind fetch_top fetch_top_assertions asrt_i (
  .clk        (clk),
  .rst        (rst),
  .fetch      (fetch),
  .fetch_valid(fetch_valid),
  .fetch_ready(fetch_ready),
  .retire     (retire)
);

// File: tests/fetch_top_tb.sv
`timescale 1ns/1ns

module fetch_top_tb import fetch_pkg::*; ();

  typedef struct packed {
    logic        ready;
    retire_upd_t retire;
    logic        exp_valid;
    addr_t       exp_ip;
    logic        exp_alias;
    logic [7:0]  test;
  } vec_t;

  logic        clk;
  logic        rst;
  logic        fetch_ready;
  retire_upd_t retire;
  fetch_req_t  fetch;
  logic        fetch_valid;
  logic        alias_error;

  vec_t   vecs [$];
  int     test_errs = 0;
  int     total_errs = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     seed = 39038;
  ghist_t exp_ghist = '0;
  addr_t  slot0_tgt [addr_t]; // trained slot-0 targets by block

  fetch_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .fetch      (fetch),
    .fetch_valid(fetch_valid),
    .fetch_ready(fetch_ready),
    .retire     (retire),
    .alias_error(alias_error)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic load_vectors();
    int          fd;
    int          n;
    int          guard;
    string       line;
    vec_t        v;
    logic [31:0] rdy, rv, rslot, rtkn, rmis, src, tgt, gh, ev, eip, eal, tnum;
    fd = $fopen("tests/fetch_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/fetch_vectors.txt");
      total_errs++;
      return;
    end
    guard = 0;
    while (!$feof(fd) && guard < 1000) begin
      guard++;
      if ($fgets(line, fd) == 0) break;
      if (line.len() == 0 || line.getc(0) == "#") continue; // comment lines
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                  rdy, rv, rslot, rtkn, rmis, src, tgt, gh, ev, eip, eal, tnum);
      if (n != 12) continue;
      v.ready             = rdy[0];
      v.retire.valid      = rv[0];
      v.retire.slot       = rslot[0];
      v.retire.taken      = rtkn[0];
      v.retire.mispredict = rmis[0];
      v.retire.src_ip     = src;
      v.retire.target     = tgt;
      v.retire.ghist      = gh[GHIST_BITS-1:0];
      v.exp_valid         = ev[0];
      v.exp_ip            = eip;
      v.exp_alias         = eal[0];
      v.test              = tnum[7:0];
      vecs.push_back(v);
    end
    $fclose(fd);
  endtask

  // outputs are stable here, between posedges
  task automatic check_outputs(input vec_t v);
    if (fetch_valid !== v.exp_valid) begin
      $display("FAIL t=%0t fetch_valid expected %0b got %0b", $time, v.exp_valid, fetch_valid);
      test_errs++;
    end
    if (fetch.ip !== v.exp_ip) begin
      $display("FAIL t=%0t fetch.ip expected %h got %h", $time, v.exp_ip, fetch.ip);
      test_errs++;
    end
    if (alias_error !== v.exp_alias) begin
      $display("FAIL t=%0t alias_error expected %0b got %0b", $time, v.exp_alias, alias_error);
      test_errs++;
    end
  endtask

  // one-hot taken slot in, 00 for fall-through
  function automatic ghist_t shift_outcome(input ghist_t h, input logic [1:0] slot_taken);
    ghist_t res;
    case (slot_taken)
      2'b01:   res = (h << 1) | ghist_t'(1);
      2'b10:   res = (h << 2) | ghist_t'(1);
      default: res = h << 2;
    endcase
    return res;
  endfunction

  // taken slot is read off the next block address
  task automatic compare_prediction(input vec_t v, input logic has_next, input addr_t next_ip);
    logic       redirect;
    logic       accept;
    logic [1:0] exp_slot;
    redirect = v.retire.valid & v.retire.mispredict;
    accept   = v.ready & ~redirect & has_next;
    exp_slot = 2'b00;
    if (fetch.ghist !== exp_ghist) begin
      $display("FAIL t=%0t fetch.ghist expected %h got %h", $time, exp_ghist, fetch.ghist);
      test_errs++;
    end
    if (accept && next_ip != v.exp_ip + addr_t'(FETCH_BYTES)) begin
      if (slot0_tgt.exists(v.exp_ip) && slot0_tgt[v.exp_ip] == next_ip) begin
        exp_slot = 2'b01;
      end else begin
        exp_slot = 2'b10;
      end
    end
    if (accept && fetch.pred_slot !== exp_slot) begin
      $display("FAIL t=%0t fetch.pred_slot expected %b got %b", $time, exp_slot,
               fetch.pred_slot);
      test_errs++;
    end
    if (redirect) begin
      if (!v.retire.taken) begin
        exp_ghist = shift_outcome(v.retire.ghist, 2'b00);
      end else begin
        exp_ghist = shift_outcome(v.retire.ghist, v.retire.slot ? 2'b10 : 2'b01);
      end
    end else if (accept) begin
      exp_ghist = shift_outcome(exp_ghist, exp_slot);
    end
    if (v.retire.valid && v.retire.taken && !v.retire.slot) begin
      slot0_tgt[v.retire.src_ip] = v.retire.target & ~addr_t'(FETCH_BYTES - 1);
    end
  endtask

  task automatic drive_inputs(input vec_t v);
    fetch_ready = v.ready;
    retire      = v.retire;
    // branch targets land anywhere inside a block
    if (v.retire.valid) begin
      retire.target[BLOCK_LSB-1:0] = BLOCK_LSB'($random(seed));
    end
  endtask

  task automatic report_test(input logic [7:0] num);
    tests_run++;
    if (test_errs == 0) begin
      $display("test %0d: pass", num);
    end else begin
      $display("test %0d: fail with %0d errors", num, test_errs);
      tests_failed++;
    end
    total_errs += test_errs;
    test_errs = 0;
  endtask

  initial begin
    int          wait_cnt;
    int          asrt_errs;
    logic        timed_out;
    logic [7:0]  cur_test;
    rst         = 1'b1;
    fetch_ready = 1'b0;
    retire      = '0;
    timed_out   = 1'b0;
    load_vectors();
    if (vecs.size() == 0) begin
      $display("no vectors loaded");
      total_errs++;
    end

    repeat (10) @(negedge clk);
    rst = 1'b0;

    wait_cnt = 0;
    while (fetch_valid !== 1'b1 && wait_cnt < 20) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (fetch_valid !== 1'b1) begin
      $display("timeout: fetch_valid never rose after reset");
      timed_out = 1'b1;
    end

    if (!timed_out && vecs.size() > 0) begin
      cur_test = vecs[0].test;
      foreach (vecs[i]) begin
        if (vecs[i].test != cur_test) begin
          report_test(cur_test);
          cur_test = vecs[i].test;
        end
        check_outputs(vecs[i]);
        if (i + 1 < vecs.size()) begin
          compare_prediction(vecs[i], 1'b1, vecs[i + 1].exp_ip);
        end else begin
          compare_prediction(vecs[i], 1'b0, '0);
        end
        drive_inputs(vecs[i]);
        @(negedge clk);
      end
      report_test(cur_test);
    end
    retire = '0;

    asrt_errs = int'(dut_i.asrt_i.err_count);
    $display("tests: %0d run, %0d failed, %0d errors, %0d assertion failures",
             tests_run, tests_failed, total_errs, asrt_errs);
    if (total_errs == 0 && asrt_errs == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: tests/fetch_vectors.txt
# rdy rv slot taken misp src_ip target ghist exp_valid exp_ip exp_alias test
# one line per cycle: expected outputs of the cycle, then the inputs applied in it
1 0 0 0 0 00000000 00000000 00 1 00001000 0 1
1 0 0 0 0 00000000 00000000 00 1 00001010 0 2
1 0 0 0 0 00000000 00000000 00 1 00001020 0 2
1 0 0 0 0 00000000 00000000 00 1 00001030 0 2
0 0 0 0 0 00000000 00000000 00 1 00001040 0 3
0 0 0 0 0 00000000 00000000 00 1 00001040 0 3
0 0 0 0 0 00000000 00000000 00 1 00001040 0 3
1 0 0 0 0 00000000 00000000 00 1 00001040 0 3
1 0 0 0 0 00000000 00000000 00 1 00001050 0 3
# slot 0 loop branch at 10c0 back to 1080
1 1 0 1 1 000010c0 00001080 00 1 00001060 0 4
1 0 0 0 0 00000000 00000000 00 1 00001080 0 4
1 0 0 0 0 00000000 00000000 00 1 00001090 0 4
1 0 0 0 0 00000000 00000000 00 1 000010a0 0 4
1 0 0 0 0 00000000 00000000 00 1 000010b0 0 4
1 0 0 0 0 00000000 00000000 00 1 000010c0 0 4
1 0 0 0 0 00000000 00000000 00 1 00001080 0 4
# both slots trained at 1200, slot 0 wins
1 1 1 1 1 00001200 00003000 00 1 00001090 0 5
1 1 0 1 1 00001200 000011c0 00 1 00003000 0 5
1 0 0 0 0 00000000 00000000 00 1 000011c0 0 5
1 0 0 0 0 00000000 00000000 00 1 000011d0 0 5
1 0 0 0 0 00000000 00000000 00 1 000011e0 0 5
1 0 0 0 0 00000000 00000000 00 1 000011f0 0 5
1 0 0 0 0 00000000 00000000 00 1 00001200 0 5
1 0 0 0 0 00000000 00000000 00 1 000011c0 0 5
# 1400 trained twice (4th mispredict flips B too), then 1800 takes its entry
1 1 0 1 1 00001400 000013c0 00 1 000011d0 0 6
1 1 0 1 1 00001400 000013c0 00 1 000013c0 0 6
1 1 0 1 0 00001800 00005000 00 1 000013c0 0 6
1 0 0 0 0 00000000 00000000 00 1 000013d0 0 6
1 0 0 0 0 00000000 00000000 00 1 000013e0 0 6
1 0 0 0 0 00000000 00000000 00 1 000013f0 0 6
1 0 0 0 0 00000000 00000000 00 1 00001400 0 6
1 0 0 0 0 00000000 00000000 00 1 00001410 1 6
1 0 0 0 0 00000000 00000000 00 1 00001420 1 6
1 0 0 0 0 00000000 00000000 00 1 00001430 1 6
